/* common/video_pkg.sv */
package video_pkg;

    // 640x480 timing at one pixel per clock
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_TOTAL  = 800;

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 525;

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

    // 4 bits per channel
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb12_t;

    // Scan position of one pixel with active-low syncs
    typedef struct packed {
        hcount_t hcount;
        vcount_t vcount;
        logic    hsync;
        logic    vsync;
        logic    blank;
    } scan_t;

    // Finished pixel with its own sync and blank
    typedef struct packed {
        rgb12_t colour;
        logic   hsync;
        logic   vsync;
        logic   blank;
    } pixel_t;

endpackage

/* common/kitchen_pkg.sv */
package kitchen_pkg;

    // Grid geometry in cells and pixels
    localparam int GRID_ROWS = 8;
    localparam int GRID_COLS = 13;
    localparam int CELL_SIZE = 32;
    localparam int CELL_BITS = 5;

    // Top-left corner of the grid on screen
    localparam int GRID_X0 = 48;
    localparam int GRID_Y0 = 96;

    // Fixed pot location
    localparam int POT_ROW = 3;
    localparam int POT_COL = 6;

    typedef logic [3:0] frame_cnt_t;

    // Frames spent raw and then cooked before the pot catches fire
    localparam frame_cnt_t COOK_FRAMES = 4'd3;
    localparam frame_cnt_t BURN_FRAMES = 4'd3;

    typedef enum logic [3:0] {
        OBJ_EMPTY        = 4'd0,
        OBJ_ONION_WHOLE  = 4'd1,
        OBJ_ONION_CHOP   = 4'd2,
        OBJ_BOWL_EMPTY   = 4'd3,
        OBJ_BOWL_FULL    = 4'd4,
        OBJ_POT_EMPTY    = 4'd5,
        OBJ_POT_RAW      = 4'd6,
        OBJ_POT_COOKED   = 4'd7,
        OBJ_POT_FIRE     = 4'd8,
        OBJ_FIRE         = 4'd9,
        OBJ_EXTINGUISHER = 4'd10
    } obj_t;

    // Row-major grid of object codes in 416 bits
    typedef obj_t [GRID_ROWS-1:0][GRID_COLS-1:0] grid_t;

    typedef enum logic [1:0] {
        POT_EMPTY,
        POT_RAW,
        POT_COOKED,
        POT_FIRE
    } pot_state_t;

endpackage

/* hw/video_timing.sv */
`timescale 1ns/1ps

module video_timing (
    input  logic             pixel_clk_in,
    input  logic             rst,
    output video_pkg::scan_t scan,
    output logic             frame_start
);
    import video_pkg::*;

    hcount_t h_q;
    vcount_t v_q;

    // Free-running counter pair
    always_ff @(posedge pixel_clk_in) begin
        if (rst) begin
            h_q <= '0;
            v_q <= '0;
        end else if (h_q == hcount_t'(H_TOTAL - 1)) begin
            h_q <= '0;
            // Last line wraps back to the top
            if (v_q == vcount_t'(V_TOTAL - 1)) begin
                v_q <= '0;
            end else begin
                v_q <= v_q + 1'b1;
            end
        end else begin
            h_q <= h_q + 1'b1;
        end
    end

    // Sync and blank decoded straight from the counters
    always_comb begin
        scan.hcount = h_q;
        scan.vcount = v_q;
        // Sync pulse starts right after the front porch
        scan.hsync  = !((h_q >= hcount_t'(H_ACTIVE + H_FRONT)) &&
                        (h_q <  hcount_t'(H_ACTIVE + H_FRONT + H_SYNC)));
        scan.vsync  = !((v_q >= vcount_t'(V_ACTIVE + V_FRONT)) &&
                        (v_q <  vcount_t'(V_ACTIVE + V_FRONT + V_SYNC)));
        // Anything outside the visible area
        scan.blank  = (h_q >= hcount_t'(H_ACTIVE)) || (v_q >= vcount_t'(V_ACTIVE));
    end

    // One cycle at the top-left pixel
    assign frame_start = (h_q == '0) && (v_q == '0);

endmodule

/* hw/cook_timer.sv */
`timescale 1ns/1ps

module cook_timer (
    input  logic                   pixel_clk_in,
    input  logic                   rst,
    input  logic                   frame_start,
    input  logic                   timer_en,
    input  logic                   timer_clr,
    output kitchen_pkg::frame_cnt_t frames
);

    // Frame counter for cooking time
    always_ff @(posedge pixel_clk_in) begin
        if (rst) begin
            frames <= '0;
        end else if (timer_clr) begin
            // Clear wins over counting
            frames <= '0;
        end else if (timer_en && frame_start) begin
            // Holds at 15 so a stall never wraps below a threshold
            if (frames != '1) begin
                frames <= frames + 1'b1;
            end
        end
    end

endmodule

/* hw/pot_cook_fsm.sv */
`timescale 1ns/1ps

module pot_cook_fsm (
    input  logic                    pixel_clk_in,
    input  logic                    rst,
    input  logic                    add_onion,
    input  logic                    extinguish,
    input  kitchen_pkg::frame_cnt_t frames,
    input  kitchen_pkg::grid_t      object_grid,
    output kitchen_pkg::grid_t      shown_grid,
    output logic                    timer_en,
    output logic                    timer_clr
);
    import kitchen_pkg::*;

    pot_state_t state;
    pot_state_t state_next;

    always_ff @(posedge pixel_clk_in) begin
        if (rst) begin
            state <= POT_EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // Next state
    always_comb begin
        state_next = state;
        if (extinguish) begin
            // Extinguisher empties the pot from any state
            state_next = POT_EMPTY;
        end else begin
            case (state)
                POT_EMPTY: begin
                    if (add_onion) begin
                        state_next = POT_RAW;
                    end
                end
                POT_RAW: begin
                    if (frames >= COOK_FRAMES) begin
                        state_next = POT_COOKED;
                    end
                end
                POT_COOKED: begin
                    // Left too long, catches fire
                    if (frames >= BURN_FRAMES) begin
                        state_next = POT_FIRE;
                    end
                end
                POT_FIRE: begin
                    // Stays burning until extinguished
                    state_next = POT_FIRE;
                end
                default: begin
                    state_next = POT_EMPTY;
                end
            endcase
        end
    end

    // Timer restarts on every state entry
    assign timer_clr = (state_next != state);
    assign timer_en  = (state == POT_RAW) || (state == POT_COOKED);

    // Pot cell always follows the FSM and ignores the input value
    always_comb begin
        shown_grid = object_grid;
        case (state)
            POT_EMPTY:  shown_grid[POT_ROW][POT_COL] = OBJ_POT_EMPTY;
            POT_RAW:    shown_grid[POT_ROW][POT_COL] = OBJ_POT_RAW;
            POT_COOKED: shown_grid[POT_ROW][POT_COL] = OBJ_POT_COOKED;
            POT_FIRE:   shown_grid[POT_ROW][POT_COL] = OBJ_POT_FIRE;
            default:    shown_grid[POT_ROW][POT_COL] = OBJ_POT_EMPTY;
        endcase
    end

endmodule

/* static_sprites/sprite_rom.sv */
`timescale 1ns/1ps

module sprite_rom (
    input  logic              pixel_clk_in,
    input  kitchen_pkg::obj_t obj,
    input  logic [4:0]        row,
    input  logic [4:0]        col,
    output logic [7:0]        index
);
    import kitchen_pkg::*;

    // One 32x32 sprite per object code at address {obj, row, col}
    logic [7:0] rom [0:16383];

    // Built from the sprite rule at elaboration
    initial begin
        for (int code = 0; code < 16; code++) begin
            for (int r = 0; r < CELL_SIZE; r++) begin
                for (int c = 0; c < CELL_SIZE; c++) begin
                    if (code == int'(OBJ_EMPTY) || code > int'(OBJ_EXTINGUISHER)) begin
                        // No sprite
                        rom[(code << 10) + (r << 5) + c] = 8'd0;
                    end else if (r == 0 || c == 0 ||
                                 r == CELL_SIZE - 1 || c == CELL_SIZE - 1) begin
                        // Outline
                        rom[(code << 10) + (r << 5) + c] = 8'd1;
                    end else begin
                        // 8x8 checkerboard shading in the object band
                        rom[(code << 10) + (r << 5) + c] =
                            8'((code * 16) + (((r / 8 + c / 8) % 2) * 2) + 4);
                    end
                end
            end
        end
    end

    // Registered read
    always_ff @(posedge pixel_clk_in) begin
        index <= rom[{obj, row, col}];
    end

endmodule

/* static_sprites/palette_lut.sv */
`timescale 1ns/1ps

module palette_lut (
    input  logic              pixel_clk_in,
    input  logic [7:0]        index,
    output video_pkg::rgb12_t colour
);
    import video_pkg::*;

    rgb12_t lut [0:255];

    // Red from the high nibble, green from the low one
    initial begin
        for (int i = 0; i < 256; i++) begin
            lut[i].red   = 4'(i >> 4);
            lut[i].green = 4'(i);
            // Blue mixes the two
            lut[i].blue  = 4'(i >> 4) ^ 4'(i);
        end
    end

    // Registered lookup
    always_ff @(posedge pixel_clk_in) begin
        colour <= lut[index];
    end

endmodule

/* static_sprites/static_sprites.sv */
`timescale 1ns/1ps

module static_sprites (
    input  logic               pixel_clk_in,
    input  logic               rst,
    input  video_pkg::scan_t   scan,
    input  kitchen_pkg::grid_t shown_grid,
    output video_pkg::pixel_t  pixel_out
);
    import video_pkg::*;
    import kitchen_pkg::*;

    // Per-pixel flags carried beside the ROM reads
    typedef struct packed {
        logic in_grid;
        logic empty;
        logic hsync;
        logic vsync;
        logic blank;
    } flags_t;

    hcount_t    dx;
    vcount_t    dy;
    logic       in_grid;
    logic [3:0] cell_col;
    logic [2:0] cell_row;
    obj_t       cell_obj;
    flags_t     flags_s0;
    flags_t     flags_s1;
    flags_t     flags_s2;
    logic [7:0] sprite_index;
    rgb12_t     pal_colour;

    // Offset from the grid corner wraps when left of or above it
    assign dx = scan.hcount - hcount_t'(GRID_X0);
    assign dy = scan.vcount - vcount_t'(GRID_Y0);

    assign in_grid = (scan.hcount >= hcount_t'(GRID_X0)) &&
                     (scan.hcount <  hcount_t'(GRID_X0 + GRID_COLS * CELL_SIZE)) &&
                     (scan.vcount >= vcount_t'(GRID_Y0)) &&
                     (scan.vcount <  vcount_t'(GRID_Y0 + GRID_ROWS * CELL_SIZE));

    // Cell index from the upper offset bits
    assign cell_col = 4'(dx >> CELL_BITS);
    assign cell_row = 3'(dy >> CELL_BITS);

    // Out-of-grid lookups never index the array
    always_comb begin
        if (in_grid) begin
            cell_obj = shown_grid[cell_row][cell_col];
        end else begin
            cell_obj = OBJ_EMPTY;
        end
    end

    always_comb begin
        flags_s0.in_grid = in_grid;
        flags_s0.empty   = (cell_obj == OBJ_EMPTY);
        flags_s0.hsync   = scan.hsync;
        flags_s0.vsync   = scan.vsync;
        flags_s0.blank   = scan.blank;
    end

    // Stage 1 reads the sprite index
    sprite_rom u_sprite_rom (
        .pixel_clk_in (pixel_clk_in),
        .obj          (cell_obj),
        .row          (dy[4:0]),
        .col          (dx[4:0]),
        .index        (sprite_index)
    );

    // Stage 2 reads the palette colour
    palette_lut u_palette_lut (
        .pixel_clk_in (pixel_clk_in),
        .index        (sprite_index),
        .colour       (pal_colour)
    );

    // Flags follow their pixel through both lookups
    always_ff @(posedge pixel_clk_in) begin
        if (rst) begin
            flags_s1 <= '{in_grid: 1'b0, empty: 1'b1, hsync: 1'b1, vsync: 1'b1, blank: 1'b1};
            flags_s2 <= '{in_grid: 1'b0, empty: 1'b1, hsync: 1'b1, vsync: 1'b1, blank: 1'b1};
        end else begin
            flags_s1 <= flags_s0;
            flags_s2 <= flags_s1;
        end
    end

    // Stage 3 selects the output colour
    always_ff @(posedge pixel_clk_in) begin
        if (rst) begin
            pixel_out <= '{colour: 12'h000, hsync: 1'b1, vsync: 1'b1, blank: 1'b0};
        end else begin
            pixel_out.hsync <= flags_s2.hsync;
            pixel_out.vsync <= flags_s2.vsync;
            pixel_out.blank <= flags_s2.blank;
            if (flags_s2.blank) begin
                pixel_out.colour <= 12'h000;
            end else if (!flags_s2.in_grid) begin
                // Dark red floor around the counter
                pixel_out.colour <= 12'h700;
            end else if (flags_s2.empty) begin
                pixel_out.colour <= 12'hFFF;
            end else begin
                pixel_out.colour <= pal_colour;
            end
        end
    end

endmodule

/* hw/kitchen_display.sv */
`timescale 1ns/1ps

module kitchen_display (
    input  logic               pixel_clk_in,
    input  logic               rst,
    input  kitchen_pkg::grid_t object_grid,
    input  logic               add_onion,
    input  logic               extinguish,
    output video_pkg::pixel_t  pixel_out
);
    import video_pkg::*;
    import kitchen_pkg::*;

    scan_t      scan;
    logic       frame_start;
    grid_t      shown_grid;
    frame_cnt_t frames;
    logic       timer_en;
    logic       timer_clr;

    video_timing u_video_timing (
        .pixel_clk_in (pixel_clk_in),
        .rst          (rst),
        .scan         (scan),
        .frame_start  (frame_start)
    );

    cook_timer u_cook_timer (
        .pixel_clk_in (pixel_clk_in),
        .rst          (rst),
        .frame_start  (frame_start),
        .timer_en     (timer_en),
        .timer_clr    (timer_clr),
        .frames       (frames)
    );

    // Pot cell overwritten before rendering
    pot_cook_fsm u_pot_cook_fsm (
        .pixel_clk_in (pixel_clk_in),
        .rst          (rst),
        .add_onion    (add_onion),
        .extinguish   (extinguish),
        .frames       (frames),
        .object_grid  (object_grid),
        .shown_grid   (shown_grid),
        .timer_en     (timer_en),
        .timer_clr    (timer_clr)
    );

    static_sprites u_static_sprites (
        .pixel_clk_in (pixel_clk_in),
        .rst          (rst),
        .scan         (scan),
        .shown_grid   (shown_grid),
        .pixel_out    (pixel_out)
    );

endmodule

/* tb/tb_kitchen_display.sv */
`timescale 1ns/1ps

module tb_kitchen_display;
    import video_pkg::*;
    import kitchen_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int PIPE_DELAY   = 3;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // Twelve frames of tests plus slack for reset and alignment
    localparam int WATCHDOG_NS  = (12 * FRAME_CYCLES + 100_000) * CLK_PERIOD;
    // Sample point inside the pot cell at column offset 10
    localparam int POT_H        = GRID_X0 + POT_COL * CELL_SIZE + 10;
    localparam int POT_V        = GRID_Y0 + POT_ROW * CELL_SIZE;
    localparam int GRID_X1      = GRID_X0 + GRID_COLS * CELL_SIZE;

    logic   pixel_clk_in = 1'b0;
    logic   rst;
    grid_t  object_grid;
    logic   add_onion;
    logic   extinguish;
    pixel_t pixel_out;

    grid_t  tb_grid;
    obj_t   pot_obj;
    int     model_h;
    int     model_v;
    int     seed;
    int     test_errors;
    int     tests_passed;
    int     tests_failed;

    kitchen_display dut (
        .pixel_clk_in (pixel_clk_in),
        .rst          (rst),
        .object_grid  (object_grid),
        .add_onion    (add_onion),
        .extinguish   (extinguish),
        .pixel_out    (pixel_out)
    );

    always #(CLK_PERIOD / 2) pixel_clk_in = ~pixel_clk_in;

    // Reference scan counter advancing one pixel per clock
    always @(posedge pixel_clk_in) begin
        if (rst) begin
            model_h <= 0;
            model_v <= 0;
        end else if (model_h == H_TOTAL - 1) begin
            model_h <= 0;
            model_v <= (model_v == V_TOTAL - 1) ? 0 : model_v + 1;
        end else begin
            model_h <= model_h + 1;
        end
    end

    // Ends a run that stops making progress
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within the frame budget");
        $display("Simulation failed");
        $finish;
    end

    function automatic int draw_below(input int n);
        int draw;
        draw = $random(seed) & 32'h7fff_ffff;
        return draw % n;
    endfunction

    // Linear scan position of the pixel now at pixel_out
    function automatic int lagged_position();
        return (model_v * H_TOTAL + model_h + FRAME_CYCLES - PIPE_DELAY) % FRAME_CYCLES;
    endfunction

    function automatic logic [7:0] sprite_index(input obj_t o, input int r, input int c);
        // Outline ring
        if (r == 0 || c == 0 || r == CELL_SIZE - 1 || c == CELL_SIZE - 1) return 8'd1;
        return 8'(16 * int'(o) + 2 * ((r / 8 + c / 8) % 2) + 4);
    endfunction

    function automatic rgb12_t palette_colour(input logic [7:0] idx);
        rgb12_t c;
        c.red   = idx[7:4];
        c.green = idx[3:0];
        c.blue  = idx[7:4] ^ idx[3:0];
        return c;
    endfunction

    // Pot cell follows the pot model, never the input grid
    function automatic obj_t cell_obj(input int r, input int c);
        if (r == POT_ROW && c == POT_COL) return pot_obj;
        return tb_grid[r][c];
    endfunction

    function automatic pixel_t expected_pixel(input int h, input int v);
        pixel_t p;
        obj_t   o;
        p = '0;
        p.hsync = !(h >= H_ACTIVE + H_FRONT && h < H_ACTIVE + H_FRONT + H_SYNC);
        p.vsync = !(v >= V_ACTIVE + V_FRONT && v < V_ACTIVE + V_FRONT + V_SYNC);
        p.blank = (h >= H_ACTIVE) || (v >= V_ACTIVE);
        if (p.blank) begin
            p.colour = 12'h000;
        end else if (h < GRID_X0 || h >= GRID_X1 || v < GRID_Y0 ||
                     v >= GRID_Y0 + GRID_ROWS * CELL_SIZE) begin
            p.colour = 12'h700;
        end else begin
            o = cell_obj((v - GRID_Y0) / CELL_SIZE, (h - GRID_X0) / CELL_SIZE);
            if (o == OBJ_EMPTY) begin
                p.colour = 12'hFFF;
            end else begin
                p.colour = palette_colour(sprite_index(o, (v - GRID_Y0) % CELL_SIZE,
                                                       (h - GRID_X0) % CELL_SIZE));
            end
        end
        return p;
    endfunction

    // Object code sits in the red nibble of every inner sprite pixel
    function automatic obj_t pixel_to_obj(input rgb12_t c);
        if (c == 12'hFFF) return OBJ_EMPTY;
        return obj_t'(c.red);
    endfunction

    function automatic obj_t cooking_obj(input int strobes);
        if (strobes < int'(COOK_FRAMES)) return OBJ_POT_RAW;
        if (strobes < int'(COOK_FRAMES) + int'(BURN_FRAMES)) return OBJ_POT_COOKED;
        return OBJ_POT_FIRE;
    endfunction

    task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_obj(input obj_t got, input obj_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %s expected %s",
                     $time, what, got.name(), exp.name());
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Stops at the negedge where pixel_out shows position (h, v)
    task automatic wait_pixel(input int h, input int v);
        int lag;
        lag = -1;
        while (lag != v * H_TOTAL + h) begin
            @(negedge pixel_clk_in);
            lag = lagged_position();
        end
    endtask

    task automatic check_here(input string what);
        int lag;
        lag = lagged_position();
        check_pixel(pixel_out, expected_pixel(lag % H_TOTAL, lag / H_TOTAL),
                    $sformatf("%s at (%0d,%0d)", what, lag % H_TOTAL, lag / H_TOTAL));
    endtask

    task automatic check_span(input int h, input int v, input int count);
        wait_pixel(h, v);
        for (int i = 0; i < count; i++) begin
            if (i > 0) @(negedge pixel_clk_in);
            check_here("scan span");
        end
    endtask

    task automatic randomize_grid();
        for (int r = 0; r < GRID_ROWS; r++) begin
            for (int c = 0; c < GRID_COLS; c++) begin
                tb_grid[r][c] = obj_t'(draw_below(int'(OBJ_EXTINGUISHER) + 1));
            end
        end
        // Input value for the pot cell that must never appear
        tb_grid[POT_ROW][POT_COL] = OBJ_FIRE;
    endtask

    task automatic pulse_add_onion();
        @(posedge pixel_clk_in);
        #1 add_onion = 1'b1;
        @(posedge pixel_clk_in);
        #1 add_onion = 1'b0;
    endtask

    task automatic pulse_extinguish();
        @(posedge pixel_clk_in);
        #1 extinguish = 1'b1;
        @(posedge pixel_clk_in);
        #1 extinguish = 1'b0;
        pot_obj = OBJ_POT_EMPTY;
    endtask

    task automatic check_pot(input int v_off, input obj_t exp);
        wait_pixel(POT_H, POT_V + v_off);
        check_obj(pixel_to_obj(pixel_out.colour), exp, "pot cell");
    endtask

    // First line, then the vertical sync rows with a line either side
    task automatic test_sync_latency();
        check_span(0, 0, H_TOTAL);
        check_span(0, V_ACTIVE + V_FRONT - 1, 4 * H_TOTAL);
        report_test("sync_latency");
    endtask

    // Left and right of the grid, and the blanking interval
    task automatic test_background();
        int h;
        int v;
        for (int i = 0; i < 16; i++) begin
            v = i * 32 + draw_below(32);
            case (i % 4)
                0, 2:    h = GRID_X1 + draw_below(H_ACTIVE - GRID_X1);
                1:       h = draw_below(GRID_X0);
                default: h = H_ACTIVE + draw_below(H_TOTAL - H_ACTIVE);
            endcase
            wait_pixel(h, v);
            check_here("background");
        end
        report_test("background");
    endtask

    // Bands of 8 rows keep the samples in scan order
    task automatic test_sprites();
        randomize_grid();
        @(posedge pixel_clk_in);
        #1 object_grid = tb_grid;
        for (int i = 0; i < 32; i++) begin
            wait_pixel(GRID_X0 + draw_below(GRID_X1 - GRID_X0), GRID_Y0 + i * 8 + draw_below(8));
            check_here("sprite");
        end
        report_test("sprites");
    endtask

    task automatic test_pot_cooking();
        wait_pixel(0, 400);
        pulse_add_onion();
        // One sample per frame strobe
        for (int k = 1; k <= int'(COOK_FRAMES) + int'(BURN_FRAMES); k++) begin
            pot_obj = cooking_obj(k);
            check_pot(8, pot_obj);
        end
        report_test("pot_cooking");
    endtask

    // Early steps fit inside the pot cell rows of one frame
    task automatic test_extinguish();
        wait_pixel(0, POT_V + 12);
        pulse_extinguish();
        check_pot(16, OBJ_POT_EMPTY);
        wait_pixel(0, POT_V + 20);
        pulse_add_onion();
        check_pot(24, OBJ_POT_RAW);
        wait_pixel(0, POT_V + 26);
        pulse_extinguish();
        check_pot(29, OBJ_POT_EMPTY);
        // Cook again, then try a second onion
        wait_pixel(0, 400);
        pulse_add_onion();
        for (int k = 1; k <= int'(COOK_FRAMES); k++) begin
            check_pot(2, cooking_obj(k));
        end
        wait_pixel(0, POT_V + 6);
        pulse_add_onion();
        check_pot(10, OBJ_POT_COOKED);
        wait_pixel(0, POT_V + 14);
        pulse_extinguish();
        check_pot(18, OBJ_POT_EMPTY);
        report_test("extinguish");
    endtask

    initial begin
        seed = 94;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        pot_obj = OBJ_POT_EMPTY;
        rst = 1'b1;
        add_onion = 1'b0;
        extinguish = 1'b0;
        randomize_grid();
        object_grid = tb_grid;
        repeat (4) @(posedge pixel_clk_in);
        #1 rst = 1'b0;

        test_sync_latency();
        test_background();
        test_sprites();
        test_pot_cooking();
        test_extinguish();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* src.f */
common/video_pkg.sv
common/kitchen_pkg.sv
hw/video_timing.sv
hw/cook_timer.sv
hw/pot_cook_fsm.sv
static_sprites/sprite_rom.sv
static_sprites/palette_lut.sv
static_sprites/static_sprites.sv
hw/kitchen_display.sv
tb/tb_kitchen_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the kitchen display testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_kitchen_display \
    -f src.f \
    -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
    exit 0
fi
exit 1
